/* div_apb_regs.sv */
`timescale 1ns/1ps

module div_apb_regs
    import div_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [APB_ADDR_WIDTH-1:0]    paddr,
    input  logic [DATA_WIDTH-1:0]        pwdata,
    output logic [DATA_WIDTH-1:0]        prdata,
    output logic                         pslverr,
    output logic                         start,
    output logic signed [DATA_WIDTH-1:0] dividend,
    output logic signed [DATA_WIDTH-1:0] divisor,
    input  logic                         done,
    input  logic signed [DATA_WIDTH-1:0] quotient,
    input  logic signed [DATA_WIDTH-1:0] remainder,
    input  logic                         div_zero,
    input  logic                         overflow
);

    logic                  busy;
    logic                  done_flag;
    logic                  div_zero_flag;
    logic                  overflow_flag;
    logic                  access;
    logic                  write_access;
    logic                  addr_known;
    logic                  operand_addr;
    logic                  write_blocked;
    logic [DATA_WIDTH-1:0] status;

    // every transfer completes in its access phase.
    assign access = psel && penable;
    assign write_access = access && pwrite;

    always_comb begin
        case (paddr)
            ADDR_DIVIDEND, ADDR_DIVISOR, ADDR_CTRL,
            ADDR_STATUS, ADDR_QUOTIENT, ADDR_REMAINDER: begin
                addr_known = 1'b1;
            end
            default: begin
                addr_known = 1'b0;
            end
        endcase
    end

    assign operand_addr = (paddr == ADDR_DIVIDEND) || (paddr == ADDR_DIVISOR) ||
                          (paddr == ADDR_CTRL);
    assign write_blocked = write_access && busy && operand_addr;
    assign pslverr = access && (!addr_known || write_blocked);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dividend <= '0;
            divisor <= '0;
            start <= 1'b0;
            busy <= 1'b0;
            done_flag <= 1'b0;
            div_zero_flag <= 1'b0;
            overflow_flag <= 1'b0;
        end else begin
            start <= 1'b0;
            if (write_access && !busy) begin
                case (paddr)
                    ADDR_DIVIDEND: begin
                        dividend <= pwdata;
                    end
                    ADDR_DIVISOR: begin
                        divisor <= pwdata;
                    end
                    ADDR_CTRL: begin
                        if (pwdata[0]) begin
                            start <= 1'b1;
                            busy <= 1'b1;
                            done_flag <= 1'b0;
                            div_zero_flag <= 1'b0;
                            overflow_flag <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            // done only arrives while busy, so it never meets a ctrl write.
            if (done) begin
                busy <= 1'b0;
                done_flag <= 1'b1;
                div_zero_flag <= div_zero;
                overflow_flag <= overflow;
            end
        end
    end

    always_comb begin
        status = '0;
        status[STATUS_BUSY] = busy;
        status[STATUS_DONE] = done_flag;
        status[STATUS_DIV_ZERO] = div_zero_flag;
        status[STATUS_OVERFLOW] = overflow_flag;
    end

    // ctrl reads back as zero, the start bit is self clearing.
    always_comb begin
        case (paddr)
            ADDR_DIVIDEND:  prdata = dividend;
            ADDR_DIVISOR:   prdata = divisor;
            ADDR_STATUS:    prdata = status;
            ADDR_QUOTIENT:  prdata = quotient;
            ADDR_REMAINDER: prdata = remainder;
            default:        prdata = '0;
        endcase
    end

endmodule

/* div_apb_top.sv */
`timescale 1ns/1ps

module div_apb_top
    import div_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [DATA_WIDTH-1:0]     pwdata,
    output logic [DATA_WIDTH-1:0]     prdata,
    output logic                      pslverr
);

    logic                         start;
    logic                         done;
    logic signed [DATA_WIDTH-1:0] dividend;
    logic signed [DATA_WIDTH-1:0] divisor;
    logic signed [DATA_WIDTH-1:0] quotient;
    logic signed [DATA_WIDTH-1:0] remainder;
    logic                         div_zero;
    logic                         overflow;

    div_apb_regs regs (
        .clock     (clock),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder),
        .div_zero  (div_zero),
        .overflow  (overflow)
    );

    fixed_point_divider divider (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder),
        .div_zero  (div_zero),
        .overflow  (overflow)
    );

endmodule

/* div_pkg.sv */
package div_pkg;

    // operands and results are signed fixed point with FRAC_BITS fractional bits.
    localparam int DATA_WIDTH = 32;
    localparam int FRAC_BITS = 10;

    // the core divides the pre-scaled dividend magnitude, so it is wider.
    localparam int CORE_WIDTH = DATA_WIDTH + FRAC_BITS;
    localparam int CORE_COUNT_WIDTH = $clog2(CORE_WIDTH + 1);

    localparam int APB_ADDR_WIDTH = 5;

    // register map, byte addresses.
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_DIVIDEND = 5'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_DIVISOR = 5'h04;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_CTRL = 5'h08;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_STATUS = 5'h0C;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_QUOTIENT = 5'h10;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_REMAINDER = 5'h14;

    // bit positions inside the status register.
    localparam int STATUS_BUSY = 0;
    localparam int STATUS_DONE = 1;
    localparam int STATUS_DIV_ZERO = 2;
    localparam int STATUS_OVERFLOW = 3;

endpackage

/* div_tb.sv */
`timescale 1ns/1ps

module div_tb
    import div_pkg::*;
();

    logic                  clock;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [DATA_WIDTH-1:0] pwdata;
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pslverr;

    // stimulus table, one entry per division.
    string                        names[$];
    logic signed [DATA_WIDTH-1:0] dividends[$];
    logic signed [DATA_WIDTH-1:0] divisors[$];
    logic signed [DATA_WIDTH-1:0] exp_quotients[$];
    logic signed [DATA_WIDTH-1:0] exp_remainders[$];
    logic                         exp_div_zeros[$];
    logic                         exp_overflows[$];

    int check_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int timeout_cycles = 0;

    div_apb_top uut (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // quotient is trunc(dividend * 2^FRAC_BITS / divisor), saturated to 32 signed bits.
    function automatic void reference_divide(input logic signed [DATA_WIDTH-1:0] a,
                                             input logic signed [DATA_WIDTH-1:0] b,
                                             output logic signed [DATA_WIDTH-1:0] q,
                                             output logic signed [DATA_WIDTH-1:0] r,
                                             output logic dz,
                                             output logic ov);
        longint num;
        longint den;
        longint q64;
        longint r64;
        q = '0;
        r = '0;
        dz = (b == 0);
        ov = 1'b0;
        if (!dz) begin
            num = longint'(a) <<< FRAC_BITS;
            den = longint'(b);
            q64 = num / den;
            r64 = num % den;
            r = r64[DATA_WIDTH-1:0];
            if (q64 > 64'sd2147483647) begin
                q = 32'h7fff_ffff;
                ov = 1'b1;
            end else if (q64 < -64'sd2147483648) begin
                q = 32'h8000_0000;
                ov = 1'b1;
            end else begin
                q = q64[DATA_WIDTH-1:0];
            end
        end
    endfunction

    task automatic add_test(input string name, input logic signed [DATA_WIDTH-1:0] a,
                            input logic signed [DATA_WIDTH-1:0] b);
        logic signed [DATA_WIDTH-1:0] q;
        logic signed [DATA_WIDTH-1:0] r;
        logic dz;
        logic ov;
        reference_divide(a, b, q, r, dz, ov);
        names.push_back(name);
        dividends.push_back(a);
        divisors.push_back(b);
        exp_quotients.push_back(q);
        exp_remainders.push_back(r);
        exp_div_zeros.push_back(dz);
        exp_overflows.push_back(ov);
    endtask

    task automatic write_register(input logic [APB_ADDR_WIDTH-1:0] addr,
                                  input logic [DATA_WIDTH-1:0] data, output logic err);
        @(posedge clock);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        err = pslverr;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_register(input logic [APB_ADDR_WIDTH-1:0] addr,
                                 output logic [DATA_WIDTH-1:0] data, output logic err);
        @(posedge clock);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        data = prdata;
        err = pslverr;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_for_done(output logic [DATA_WIDTH-1:0] status);
        logic err;
        status = '0;
        while (!status[STATUS_DONE]) begin
            read_register(ADDR_STATUS, status, err);
        end
    endtask

    task automatic compare_value(input string test_name, input string field,
                                 input logic [DATA_WIDTH-1:0] expected,
                                 input logic [DATA_WIDTH-1:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s %s: expected %h, actual %h",
                     test_name, field, expected, actual);
            check_errors++;
        end
    endtask

    task automatic finish_test(input string test_name, input int errors_before);
        if (check_errors == errors_before) begin
            tests_passed++;
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d checks wrong", test_name, check_errors - errors_before);
        end
    endtask

    task automatic run_entry(input int idx);
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] status;
        logic err;
        int errors_before;
        errors_before = check_errors;
        write_register(ADDR_DIVIDEND, dividends[idx], err);
        compare_value(names[idx], "pslverr on dividend write", 0, err);
        write_register(ADDR_DIVISOR, divisors[idx], err);
        compare_value(names[idx], "pslverr on divisor write", 0, err);
        write_register(ADDR_CTRL, 32'h1, err);
        compare_value(names[idx], "pslverr on ctrl write", 0, err);
        wait_for_done(status);
        compare_value(names[idx], "div_zero", exp_div_zeros[idx], status[STATUS_DIV_ZERO]);
        compare_value(names[idx], "overflow", exp_overflows[idx], status[STATUS_OVERFLOW]);
        compare_value(names[idx], "busy", 0, status[STATUS_BUSY]);
        read_register(ADDR_QUOTIENT, data, err);
        compare_value(names[idx], "quotient", exp_quotients[idx], data);
        read_register(ADDR_REMAINDER, data, err);
        compare_value(names[idx], "remainder", exp_remainders[idx], data);
        finish_test(names[idx], errors_before);
    endtask

    // an unknown address and an operand write during a division must both be refused.
    task automatic check_bus_errors();
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] status;
        logic signed [DATA_WIDTH-1:0] q;
        logic signed [DATA_WIDTH-1:0] r;
        logic dz;
        logic ov;
        logic err;
        int errors_before;
        errors_before = check_errors;
        reference_divide(32'sd10240, 32'sd4096, q, r, dz, ov);
        read_register(5'h18, data, err);
        compare_value("apb_errors", "pslverr on unknown address", 1, err);
        write_register(ADDR_DIVIDEND, 32'sd10240, err);
        write_register(ADDR_DIVISOR, 32'sd4096, err);
        write_register(ADDR_CTRL, 32'h1, err);
        read_register(ADDR_STATUS, status, err);
        compare_value("apb_errors", "busy after start", 1, status[STATUS_BUSY]);
        write_register(ADDR_DIVISOR, 32'sd1, err);
        compare_value("apb_errors", "pslverr on busy divisor write", 1, err);
        wait_for_done(status);
        compare_value("apb_errors", "div_zero", dz, status[STATUS_DIV_ZERO]);
        compare_value("apb_errors", "overflow", ov, status[STATUS_OVERFLOW]);
        read_register(ADDR_QUOTIENT, data, err);
        compare_value("apb_errors", "quotient", q, data);
        read_register(ADDR_REMAINDER, data, err);
        compare_value("apb_errors", "remainder", r, data);
        read_register(ADDR_DIVISOR, data, err);
        compare_value("apb_errors", "divisor register", 32'sd4096, data);
        finish_test("apb_errors", errors_before);
    endtask

    initial begin
        logic signed [DATA_WIDTH-1:0] a;
        logic signed [DATA_WIDTH-1:0] b;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        void'($urandom(32'hd9d6));

        // operands in Q21.10, so 1.0 is 1024.
        add_test("pos_exact", 32'sd3072, 32'sd2048);
        add_test("pos_inexact", 32'sd1024, 32'sd3072);
        add_test("neg_by_pos", -32'sd7680, 32'sd2304);
        add_test("pos_by_neg", 32'sd7680, -32'sd2304);
        add_test("neg_by_neg", -32'sd7680, -32'sd2304);
        add_test("zero_divisor", 32'sd5120, 32'sd0);
        add_test("sat_positive", 32'sh4000_0000, 32'sd1);
        add_test("sat_negative", 32'sh4000_0000, -32'sd1);
        add_test("min_by_unit", 32'sh8000_0000, 32'sd1024);
        for (int i = 0; i < 20; i++) begin
            a = $urandom;
            b = $urandom;
            b = b >>> ($urandom % 24);
            if (b == 0) begin
                b = 1;
            end
            add_test($sformatf("random_%0d", i), a, b);
        end
        timeout_cycles = (names.size() + 1) * 200;

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < names.size(); i++) begin
            run_entry(i);
        end
        check_bus_errors();

        $display("summary: %0d tests ok, %0d tests wrong", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clock);
        $display("timeout: the divisions did not finish within %0d cycles", timeout_cycles);
        $display("test failed");
        $finish;
    end

endmodule

/* fixed_point_divider.sv */
`timescale 1ns/1ps

module fixed_point_divider
    import div_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic signed [DATA_WIDTH-1:0] dividend,
    input  logic signed [DATA_WIDTH-1:0] divisor,
    output logic                         done,
    output logic signed [DATA_WIDTH-1:0] quotient,
    output logic signed [DATA_WIDTH-1:0] remainder,
    output logic                         div_zero,
    output logic                         overflow
);

    logic                         running;
    logic                         accept;
    logic                         core_start;
    logic                         core_done;
    logic [DATA_WIDTH-1:0]        dividend_abs;
    logic [DATA_WIDTH-1:0]        divisor_abs;
    logic [CORE_WIDTH-1:0]        dividend_mag;
    logic [DATA_WIDTH-1:0]        divisor_mag;
    logic [CORE_WIDTH-1:0]        quotient_mag;
    logic [DATA_WIDTH-1:0]        remainder_mag;
    logic                         neg_quot;
    logic                         neg_rem;
    logic                         quot_over;
    logic signed [DATA_WIDTH-1:0] quotient_c;
    logic signed [DATA_WIDTH-1:0] remainder_c;

    assign accept = start && !running;

    // the most negative operand still has a representable magnitude when unsigned.
    assign dividend_abs = dividend[DATA_WIDTH-1] ? -dividend : dividend;
    assign divisor_abs = divisor[DATA_WIDTH-1] ? -divisor : divisor;

    // a negative quotient may reach one step further than a positive one.
    assign quot_over = neg_quot ?
        (|quotient_mag[CORE_WIDTH-1:DATA_WIDTH] ||
         (quotient_mag[DATA_WIDTH-1] && |quotient_mag[DATA_WIDTH-2:0])) :
        |quotient_mag[CORE_WIDTH-1:DATA_WIDTH-1];

    always_comb begin
        if (quot_over) begin
            quotient_c = neg_quot ? {1'b1, {(DATA_WIDTH-1){1'b0}}}
                                  : {1'b0, {(DATA_WIDTH-1){1'b1}}};
        end else if (neg_quot) begin
            quotient_c = -quotient_mag[DATA_WIDTH-1:0];
        end else begin
            quotient_c = quotient_mag[DATA_WIDTH-1:0];
        end
        remainder_c = neg_rem ? -remainder_mag : remainder_mag;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            core_start <= 1'b0;
            done <= 1'b0;
            quotient <= '0;
            remainder <= '0;
            div_zero <= 1'b0;
            overflow <= 1'b0;
        end else begin
            core_start <= 1'b0;
            done <= 1'b0;
            if (accept) begin
                if (divisor == '0) begin
                    // zero divisor finishes at once without the core.
                    quotient <= '0;
                    remainder <= '0;
                    div_zero <= 1'b1;
                    overflow <= 1'b0;
                    done <= 1'b1;
                end else begin
                    running <= 1'b1;
                    core_start <= 1'b1;
                end
            end else if (core_done) begin
                running <= 1'b0;
                done <= 1'b1;
                quotient <= quotient_c;
                remainder <= remainder_c;
                div_zero <= 1'b0;
                overflow <= quot_over;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            dividend_mag <= {dividend_abs, {FRAC_BITS{1'b0}}};
            divisor_mag <= divisor_abs;
            neg_quot <= dividend[DATA_WIDTH-1] ^ divisor[DATA_WIDTH-1];
            neg_rem <= dividend[DATA_WIDTH-1];
        end
    end

    nonrestoring_divider core (
        .clock         (clock),
        .reset         (reset),
        .core_start    (core_start),
        .dividend_mag  (dividend_mag),
        .divisor_mag   (divisor_mag),
        .core_done     (core_done),
        .quotient_mag  (quotient_mag),
        .remainder_mag (remainder_mag)
    );

endmodule

/* nonrestoring_divider.sv */
`timescale 1ns/1ps

module nonrestoring_divider
    import div_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  core_start,
    input  logic [CORE_WIDTH-1:0] dividend_mag,
    input  logic [DATA_WIDTH-1:0] divisor_mag,
    output logic                  core_done,
    output logic [CORE_WIDTH-1:0] quotient_mag,
    output logic [DATA_WIDTH-1:0] remainder_mag
);

    typedef enum logic [1:0] {
        IDLE,
        ITERATE,
        FINISH
    } state_t;

    state_t state;
    state_t next_state;

    // upper DATA_WIDTH+1 bits hold the signed partial remainder, the lower
    // CORE_WIDTH bits start as the dividend and fill up with quotient bits.
    logic [DATA_WIDTH+CORE_WIDTH:0] aq;
    logic [DATA_WIDTH+CORE_WIDTH:0] aq_c;
    logic [DATA_WIDTH-1:0]          divisor_reg;
    logic [DATA_WIDTH-1:0]          divisor_reg_c;
    logic [CORE_COUNT_WIDTH-1:0]    count;
    logic [CORE_COUNT_WIDTH-1:0]    count_c;
    logic [DATA_WIDTH:0]            partial;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            count <= '0;
        end else begin
            state <= next_state;
            count <= count_c;
        end
    end

    always_ff @(posedge clock) begin
        aq <= aq_c;
        divisor_reg <= divisor_reg_c;
    end

    always_comb begin
        next_state = state;
        aq_c = aq;
        divisor_reg_c = divisor_reg;
        count_c = count;
        partial = aq[DATA_WIDTH+CORE_WIDTH -: DATA_WIDTH+1];

        case (state)
            IDLE: begin
                if (core_start) begin
                    aq_c = {{(DATA_WIDTH+1){1'b0}}, dividend_mag};
                    divisor_reg_c = divisor_mag;
                    count_c = '0;
                    next_state = ITERATE;
                end
            end

            ITERATE: begin
                aq_c = aq << 1;
                partial = aq_c[DATA_WIDTH+CORE_WIDTH -: DATA_WIDTH+1];
                // the sign of the remainder before the shift picks add or subtract.
                if (aq[DATA_WIDTH+CORE_WIDTH]) begin
                    partial = partial + {1'b0, divisor_reg};
                end else begin
                    partial = partial - {1'b0, divisor_reg};
                end
                aq_c[0] = ~partial[DATA_WIDTH];

                if (count == CORE_COUNT_WIDTH'(CORE_WIDTH - 1)) begin
                    // a negative final remainder gets one restoring add.
                    if (partial[DATA_WIDTH]) begin
                        partial = partial + {1'b0, divisor_reg};
                    end
                    next_state = FINISH;
                end

                aq_c[DATA_WIDTH+CORE_WIDTH -: DATA_WIDTH+1] = partial;
                count_c = count + 1'b1;
            end

            FINISH: begin
                next_state = IDLE;
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign core_done = (state == FINISH);
    assign quotient_mag = aq[CORE_WIDTH-1:0];
    assign remainder_mag = aq[CORE_WIDTH +: DATA_WIDTH];

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module div_tb -f sources.f -o div_sim

output=$(./obj_dir/div_sim)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* sources.f */
div_pkg.sv
nonrestoring_divider.sv
fixed_point_divider.sv
div_apb_regs.sv
div_apb_top.sv
div_tb.sv
